// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

   // Word and index sizes
   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 5;
   localparam int imemDepth    = 64;
   localparam int dmemDepth    = 64;
   localparam int memIdxWidth  = 6;

   // Primary opcodes in bits 31:26
   localparam logic [5:0] opRtype = 6'h00;
   localparam logic [5:0] opAddi  = 6'h08;
   localparam logic [5:0] opLw    = 6'h23;
   localparam logic [5:0] opSw    = 6'h2b;
   localparam logic [5:0] opBeq   = 6'h04;

   // R-type function codes
   localparam logic [5:0] fnAdd = 6'h20;
   localparam logic [5:0] fnSub = 6'h22;
   localparam logic [5:0] fnAnd = 6'h24;
   localparam logic [5:0] fnOr  = 6'h25;
   localparam logic [5:0] fnSlt = 6'h2a;

   // ALUOp from main decode
   typedef logic [1:0] aluOpT;
   localparam aluOpT aluOpAdd   = 2'b00;
   localparam aluOpT aluOpSub   = 2'b01;
   localparam aluOpT aluOpFunct = 2'b10;

   // ALU operation select, textbook encoding
   typedef logic [3:0] aluCtrlT;
   localparam aluCtrlT aluAnd = 4'b0000;
   localparam aluCtrlT aluOr  = 4'b0001;
   localparam aluCtrlT aluAdd = 4'b0010;
   localparam aluCtrlT aluSub = 4'b0110;
   localparam aluCtrlT aluSlt = 4'b0111;

   // Operand source in execute
   typedef logic [1:0] fwdSelT;
   localparam fwdSelT fwdReg = 2'b00;
   localparam fwdSelT fwdWb  = 2'b01;
   localparam fwdSelT fwdMem = 2'b10;

   typedef struct packed {
      logic [5:0]              op;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [4:0]              shamt;
      logic [5:0]              funct;
   } rFieldsT;

   typedef struct packed {
      logic [5:0]              op;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [15:0]             imm;
   } iFieldsT;

   // One instruction word, two field layouts
   typedef union packed {
      rFieldsT r;
      iFieldsT i;
   } instrT;

   typedef struct packed {
      logic  regWrite;
      logic  memToReg;
      logic  branch;
      logic  memRead;
      logic  memWrite;
      logic  regDst;
      logic  aluSrc;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      ctrlT                 ctrl;
      logic [dataWidth-1:0] pcPlus4;
      logic [dataWidth-1:0] rsData;
      logic [dataWidth-1:0] rtData;
      logic [dataWidth-1:0] signExt;
      instrT                instr;
   } idExT;

   typedef struct packed {
      logic                    regWrite;
      logic                    memToReg;
      logic                    branch;
      logic                    memRead;
      logic                    memWrite;
      logic [dataWidth-1:0]    branchDest;
      logic                    zero;
      logic [dataWidth-1:0]    aluResult;
      logic [dataWidth-1:0]    storeData;
      logic [regAddrWidth-1:0] destReg;
   } exMemT;

   typedef struct packed {
      logic                    regWrite;
      logic                    memToReg;
      logic [dataWidth-1:0]    loadData;
      logic [dataWidth-1:0]    aluResult;
      logic [regAddrWidth-1:0] destReg;
   } memWbT;

   // Retiring register write
   typedef struct packed {
      logic                    valid;
      logic [regAddrWidth-1:0] regAddr;
      logic [dataWidth-1:0]    data;
   } wbT;

endpackage

`default_nettype wire

// ==== source/fetchUnit.sv ====
`default_nettype none

module fetchUnit (
   input  logic                            Clk,
   input  logic                            rstN,
   input  logic                            imemWe,
   input  logic [mipsPkg::memIdxWidth-1:0] imemAddr,
   input  logic [mipsPkg::dataWidth-1:0]   imemData,
   input  logic                            stall,
   input  logic                            flush,
   input  logic                            takeBranch,
   input  logic [mipsPkg::dataWidth-1:0]   branchDest,
   output logic [mipsPkg::dataWidth-1:0]   ifIdInstr,
   output logic [mipsPkg::dataWidth-1:0]   ifIdPcPlus4
);
   import mipsPkg::*;

   // Program store, one word per entry
   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcPlus4;
   logic [dataWidth-1:0] fetchWord;

   assign pcPlus4 = pc + 32'd4;

   // Byte PC down to word index
   assign fetchWord = imem[pc[memIdxWidth+1:2]];

   // Loader writes only while core held in reset
   always_ff @(posedge Clk) begin
      if (!rstN && imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   // Redirect first, then stall hold
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (takeBranch) begin
         pc <= branchDest;
      end else if (!stall) begin
         pc <= pcPlus4;
      end
   end

   // Cleared word decodes as sll $0 so acts as no-op
   // flush beats stall here
   always_ff @(posedge Clk) begin
      if (!rstN || flush) begin
         ifIdInstr   <= '0;
         ifIdPcPlus4 <= '0;
      end else if (!stall) begin
         ifIdInstr   <= fetchWord;
         ifIdPcPlus4 <= pcPlus4;
      end
   end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`default_nettype none

module registerFile (
   input  logic                             Clk,
   input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
   input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
   output logic [mipsPkg::dataWidth-1:0]    rsData,
   output logic [mipsPkg::dataWidth-1:0]    rtData,
   input  mipsPkg::wbT                      wb
);
   import mipsPkg::*;

   logic [dataWidth-1:0] regs [2**regAddrWidth];

   // Read with $0 tied low and same-cycle writeback bypass
   function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
      if (addr == '0) begin
         return '0;
      end
      if (wb.valid && wb.regAddr == addr) begin
         return wb.data;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rsData = readPort(rsAddr);
      rtData = readPort(rtAddr);
   end

   // wb.valid already excludes $0
   always_ff @(posedge Clk) begin
      if (wb.valid) begin
         regs[wb.regAddr] <= wb.data;
      end
   end

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
`default_nettype none

module decodeStage (
   input  logic                             Clk,
   input  logic                             rstN,
   input  logic [mipsPkg::dataWidth-1:0]    ifIdInstr,
   input  logic [mipsPkg::dataWidth-1:0]    ifIdPcPlus4,
   input  logic                             stall,
   input  logic                             flush,
   input  mipsPkg::wbT                      wb,
   output mipsPkg::idExT                    idEx,
   output logic                             idExValid,
   output logic [mipsPkg::regAddrWidth-1:0] rsAddr,
   output logic [mipsPkg::regAddrWidth-1:0] rtAddr
);
   import mipsPkg::*;

   instrT                instr;
   ctrlT                 ctrl;
   logic [dataWidth-1:0] rsData;
   logic [dataWidth-1:0] rtData;
   logic [dataWidth-1:0] signExt;

   assign instr  = ifIdInstr;
   assign rsAddr = instr.r.rs;
   assign rtAddr = instr.r.rt;

   // Immediate widened with its sign bit
   assign signExt = {{16{instr.i.imm[15]}}, instr.i.imm};

   registerFile regFile (
      .Clk    (Clk),
      .rsAddr (rsAddr),
      .rtAddr (rtAddr),
      .rsData (rsData),
      .rtData (rtData),
      .wb     (wb)
   );

   // Main control, unknown opcodes fall out as no-ops
   always_comb begin
      ctrl = '0;
      case (instr.i.op)
         opRtype: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            ctrl.aluOp    = aluOpFunct;
         end
         opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = aluOpAdd;
         end
         opLw: begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = aluOpAdd;
         end
         opSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = aluOpAdd;
         end
         // Compare by subtraction, zero flag decides
         opBeq: begin
            ctrl.branch = 1'b1;
            ctrl.aluOp  = aluOpSub;
         end
         default: begin
            ctrl = '0;
         end
      endcase
   end

   // Bubble on stall or flush
   always_ff @(posedge Clk) begin
      if (!rstN || stall || flush) begin
         idExValid <= 1'b0;
      end else begin
         idExValid <= 1'b1;
      end
   end

   // Payload follows decode every cycle
   always_ff @(posedge Clk) begin
      idEx.ctrl    <= ctrl;
      idEx.pcPlus4 <= ifIdPcPlus4;
      idEx.rsData  <= rsData;
      idEx.rtData  <= rtData;
      idEx.signExt <= signExt;
      idEx.instr   <= instr;
   end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`default_nettype none

module executeStage (
   input  logic            Clk,
   input  logic            rstN,
   input  mipsPkg::idExT   idEx,
   input  logic            idExValid,
   input  mipsPkg::fwdSelT fwdA,
   input  mipsPkg::fwdSelT fwdB,
   input  logic            flush,
   input  mipsPkg::wbT     wb,
   output mipsPkg::exMemT  exMem,
   output logic            exMemValid
);
   import mipsPkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluResult;
   logic [dataWidth-1:0] branchDest;
   logic                 zero;
   aluCtrlT              aluCtrl;

   // Memory-stage result comes from own output register
   function automatic logic [dataWidth-1:0] forwardMux(input fwdSelT sel,
                                                       input logic [dataWidth-1:0] regVal);
      case (sel)
         fwdMem:  return exMem.aluResult;
         fwdWb:   return wb.data;
         default: return regVal;
      endcase
   endfunction

   always_comb begin
      opA = forwardMux(fwdA, idEx.rsData);
      opB = forwardMux(fwdB, idEx.rtData);
   end

   // Immediate replaces rt for addi, lw, sw
   assign aluB = idEx.ctrl.aluSrc ? idEx.signExt : opB;

   // ALU control from ALUOp and funct
   always_comb begin
      case (idEx.ctrl.aluOp)
         aluOpAdd: aluCtrl = aluAdd;
         aluOpSub: aluCtrl = aluSub;
         default: begin
            case (idEx.instr.r.funct)
               fnAdd:   aluCtrl = aluAdd;
               fnSub:   aluCtrl = aluSub;
               fnAnd:   aluCtrl = aluAnd;
               fnOr:    aluCtrl = aluOr;
               fnSlt:   aluCtrl = aluSlt;
               default: aluCtrl = aluAdd;
            endcase
         end
      endcase
   end

   always_comb begin
      case (aluCtrl)
         aluAnd:  aluResult = opA & aluB;
         aluOr:   aluResult = opA | aluB;
         aluSub:  aluResult = opA - aluB;
         aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(aluB)};
         default: aluResult = opA + aluB;
      endcase
   end

   assign zero = (aluResult == '0);

   // Word offset relative to pc+4
   assign branchDest = idEx.pcPlus4 + {idEx.signExt[dataWidth-3:0], 2'b00};

   always_ff @(posedge Clk) begin
      if (!rstN || flush) begin
         exMemValid <= 1'b0;
      end else begin
         exMemValid <= idExValid;
      end
   end

   always_ff @(posedge Clk) begin
      exMem.regWrite   <= idEx.ctrl.regWrite;
      exMem.memToReg   <= idEx.ctrl.memToReg;
      exMem.branch     <= idEx.ctrl.branch;
      exMem.memRead    <= idEx.ctrl.memRead;
      exMem.memWrite   <= idEx.ctrl.memWrite;
      exMem.branchDest <= branchDest;
      exMem.zero       <= zero;
      exMem.aluResult  <= aluResult;
      // Store data is the forwarded rt, not the immediate
      exMem.storeData  <= opB;
      exMem.destReg    <= idEx.ctrl.regDst ? idEx.instr.r.rd : idEx.instr.r.rt;
   end

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
`default_nettype none

module memoryStage (
   input  logic                          Clk,
   input  logic                          rstN,
   input  mipsPkg::exMemT                exMem,
   input  logic                          exMemValid,
   output logic                          takeBranch,
   output logic [mipsPkg::dataWidth-1:0] branchDest,
   output mipsPkg::wbT                   wb,
   output logic                          dmemWe,
   output logic [mipsPkg::dataWidth-1:0] dmemAddr,
   output logic [mipsPkg::dataWidth-1:0] dmemData
);
   import mipsPkg::*;

   logic [dataWidth-1:0]   dmem [dmemDepth];
   logic [memIdxWidth-1:0] memIdx;
   logic [dataWidth-1:0]   readData;
   memWbT                  memWb;
   logic                   memWbValid;

   // Byte address, word aligned access
   assign memIdx   = exMem.aluResult[memIdxWidth+1:2];
   assign readData = exMem.memRead ? dmem[memIdx] : '0;

   assign dmemWe   = exMemValid && exMem.memWrite;
   assign dmemAddr = exMem.aluResult;
   assign dmemData = exMem.storeData;

   always_ff @(posedge Clk) begin
      if (dmemWe) begin
         dmem[memIdx] <= exMem.storeData;
      end
   end

   // beq taken when operands subtract to zero
   assign takeBranch = exMemValid && exMem.branch && exMem.zero;
   assign branchDest = exMem.branchDest;

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         memWbValid <= 1'b0;
      end else begin
         memWbValid <= exMemValid;
      end
   end

   always_ff @(posedge Clk) begin
      memWb.regWrite  <= exMem.regWrite;
      memWb.memToReg  <= exMem.memToReg;
      memWb.loadData  <= readData;
      memWb.aluResult <= exMem.aluResult;
      memWb.destReg   <= exMem.destReg;
   end

   // Writes to $0 never retire
   assign wb.valid   = memWbValid && memWb.regWrite && (memWb.destReg != '0);
   assign wb.regAddr = memWb.destReg;
   assign wb.data    = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
   input  logic [mipsPkg::dataWidth-1:0] ifIdInstr,
   input  mipsPkg::idExT                 idEx,
   input  logic                          idExValid,
   input  mipsPkg::exMemT                exMem,
   input  logic                          exMemValid,
   input  mipsPkg::wbT                   wb,
   input  logic                          takeBranch,
   output mipsPkg::fwdSelT               fwdA,
   output mipsPkg::fwdSelT               fwdB,
   output logic                          stall,
   output logic                          flush
);
   import mipsPkg::*;

   instrT                   idInstr;
   logic [regAddrWidth-1:0] loadDest;

   // Newer producer in memory wins over writeback
   function automatic fwdSelT selectSource(input logic [regAddrWidth-1:0] src);
      if (exMemValid && exMem.regWrite && exMem.destReg != '0 && exMem.destReg == src) begin
         return fwdMem;
      end
      // wb.valid never set for $0
      if (wb.valid && wb.regAddr == src) begin
         return fwdWb;
      end
      return fwdReg;
   endfunction

   always_comb begin
      fwdA = selectSource(idEx.instr.r.rs);
      fwdB = selectSource(idEx.instr.r.rt);
   end

   assign idInstr  = ifIdInstr;
   // lw writes rt
   assign loadDest = idEx.instr.r.rt;

   // Load data not ready for the very next instruction
   assign stall = idExValid && idEx.ctrl.memRead && (loadDest != '0) &&
                  (loadDest == idInstr.r.rs || loadDest == idInstr.r.rt);

   // Three younger instructions dropped on a taken beq
   assign flush = takeBranch;

endmodule

`default_nettype wire

// ==== source/mipsCore.sv ====
`default_nettype none

module mipsCore (
   input  logic                             Clk,
   input  logic                             rstN,
   input  logic                             imemWe,
   input  logic [mipsPkg::memIdxWidth-1:0]  imemAddr,
   input  logic [mipsPkg::dataWidth-1:0]    imemData,
   output logic                             wbValid,
   output logic [mipsPkg::regAddrWidth-1:0] wbReg,
   output logic [mipsPkg::dataWidth-1:0]    wbData,
   output logic                             dmemWe,
   output logic [mipsPkg::dataWidth-1:0]    dmemAddr,
   output logic [mipsPkg::dataWidth-1:0]    dmemData
);
   import mipsPkg::*;

   // Fetch to decode
   logic [dataWidth-1:0] ifIdInstr;
   logic [dataWidth-1:0] ifIdPcPlus4;
   // Stage payloads
   idExT                 idEx;
   logic                 idExValid;
   exMemT                exMem;
   logic                 exMemValid;
   wbT                   wb;
   // Redirect and hazard controls
   logic                 takeBranch;
   logic [dataWidth-1:0] branchDest;
   fwdSelT               fwdA;
   fwdSelT               fwdB;
   logic                 stall;
   logic                 flush;

   fetchUnit fetch (
      .Clk         (Clk),
      .rstN        (rstN),
      .imemWe      (imemWe),
      .imemAddr    (imemAddr),
      .imemData    (imemData),
      .stall       (stall),
      .flush       (flush),
      .takeBranch  (takeBranch),
      .branchDest  (branchDest),
      .ifIdInstr   (ifIdInstr),
      .ifIdPcPlus4 (ifIdPcPlus4)
   );

   // Hazard unit decodes rs/rt from ifIdInstr itself
   decodeStage decode (
      .Clk         (Clk),
      .rstN        (rstN),
      .ifIdInstr   (ifIdInstr),
      .ifIdPcPlus4 (ifIdPcPlus4),
      .stall       (stall),
      .flush       (flush),
      .wb          (wb),
      .idEx        (idEx),
      .idExValid   (idExValid),
      .rsAddr      (),
      .rtAddr      ()
   );

   executeStage execute (
      .Clk        (Clk),
      .rstN       (rstN),
      .idEx       (idEx),
      .idExValid  (idExValid),
      .fwdA       (fwdA),
      .fwdB       (fwdB),
      .flush      (flush),
      .wb         (wb),
      .exMem      (exMem),
      .exMemValid (exMemValid)
   );

   memoryStage memory (
      .Clk        (Clk),
      .rstN       (rstN),
      .exMem      (exMem),
      .exMemValid (exMemValid),
      .takeBranch (takeBranch),
      .branchDest (branchDest),
      .wb         (wb),
      .dmemWe     (dmemWe),
      .dmemAddr   (dmemAddr),
      .dmemData   (dmemData)
   );

   hazardUnit hazard (
      .ifIdInstr  (ifIdInstr),
      .idEx       (idEx),
      .idExValid  (idExValid),
      .exMem      (exMem),
      .exMemValid (exMemValid),
      .wb         (wb),
      .takeBranch (takeBranch),
      .fwdA       (fwdA),
      .fwdB       (fwdB),
      .stall      (stall),
      .flush      (flush)
   );

   // Retirement port
   assign wbValid = wb.valid;
   assign wbReg   = wb.regAddr;
   assign wbData  = wb.data;

endmodule

`default_nettype wire

// ==== sim/core_properties.sv ====
`default_nettype none

module coreProperties (
   input logic                             Clk,
   input logic                             rstN,
   input logic                             wbValid,
   input logic [mipsPkg::regAddrWidth-1:0] wbReg,
   input logic [mipsPkg::dataWidth-1:0]    wbData,
   input logic                             dmemWe,
   input logic [mipsPkg::dataWidth-1:0]    dmemData
);
   import mipsPkg::*;

   // Strobes quiet once reset has reached the stage registers
   quietInReset: assert property (@(posedge Clk) !rstN |=> (!wbValid && !dmemWe))
      else $error("retire or store strobe active during reset");

   // $0 writes never leave the core
   noZeroRetire: assert property (@(posedge Clk) disable iff (!rstN) wbValid |-> (wbReg != '0))
      else $error("retirement to register zero");

   // Known data whenever a strobe is up
   knownWbData: assert property (@(posedge Clk) disable iff (!rstN)
                                 wbValid |-> !$isunknown(wbData))
      else $error("unknown bits on retired data");

   knownStoreData: assert property (@(posedge Clk) disable iff (!rstN)
                                    dmemWe |-> !$isunknown(dmemData))
      else $error("unknown bits on store data");

endmodule

`default_nettype wire

// ==== sim/mipsTb.sv ====
`default_nettype none

module mipsTb;
   import mipsPkg::*;

   localparam int period     = 100;
   localparam int drainLimit = 3000;
   localparam int runLimit   = 40000;

   logic                    Clk;
   logic                    rstN;
   logic                    imemWe;
   logic [memIdxWidth-1:0]  imemAddr;
   logic [dataWidth-1:0]    imemData;
   logic                    wbValid;
   logic [regAddrWidth-1:0] wbReg;
   logic [dataWidth-1:0]    wbData;
   logic                    dmemWe;
   logic [dataWidth-1:0]    dmemAddr;
   logic [dataWidth-1:0]    dmemData;

   // Program image and ISA model state
   logic [31:0] prog [imemDepth];
   logic [31:0] modelRegs [32];
   logic [31:0] modelMem [dmemDepth];
   int          haltIdx;

   // Expected events in program order
   logic [4:0]  expRegQ [$];
   logic [31:0] expValQ [$];
   logic [31:0] expAddrQ [$];
   logic [31:0] expDataQ [$];

   string testName;
   int    testErrors;
   int    totalErrors;
   int    testsRun;
   int    testsFailed;
   int    cyclesOut;

   mipsCore DUT (
      .Clk      (Clk),
      .rstN     (rstN),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .dmemWe   (dmemWe),
      .dmemAddr (dmemAddr),
      .dmemData (dmemData)
   );

   initial begin
      Clk = 1'b0;
      forever #(period/2) Clk = ~Clk;
   end

   // Cycles since reset release, saturating
   always @(posedge Clk) begin
      if (!rstN) begin
         cyclesOut <= 0;
      end else if (cyclesOut < 1000) begin
         cyclesOut <= cyclesOut + 1;
      end
   end

   task automatic valueMismatch(input string what, input logic [63:0] expVal,
                                input logic [63:0] actVal);
      $display("CHECK FAILED %s %s: expected %h, actual %h", testName, what, expVal, actVal);
      testErrors++;
   endtask

   task automatic reportFailure(input string msg);
      $display("Test %s: %s", testName, msg);
      testErrors++;
   endtask

   // Outputs settle after the rising edge, sampled on the falling one
   always @(negedge Clk) begin
      if (rstN === 1'b1) begin
         if (wbValid || dmemWe) begin
            assert (cyclesOut >= 4)
               else reportFailure("strobe fired before the fourth cycle after reset");
         end
         if (wbValid) begin
            assert (expRegQ.size() > 0)
               else reportFailure("a register write retired that the program never makes");
            if (expRegQ.size() > 0) begin
               assert ({expRegQ[0], expValQ[0]} == {wbReg, wbData})
                  else valueMismatch("retire reg/data", 64'({expRegQ[0], expValQ[0]}),
                                     64'({wbReg, wbData}));
               void'(expRegQ.pop_front());
               void'(expValQ.pop_front());
            end
         end
         if (dmemWe) begin
            assert (expAddrQ.size() > 0)
               else reportFailure("a store happened that the program never makes");
            if (expAddrQ.size() > 0) begin
               assert ({expAddrQ[0], expDataQ[0]} == {dmemAddr, dmemData})
                  else valueMismatch("store addr/data", {expAddrQ[0], expDataQ[0]},
                                     {dmemAddr, dmemData});
               void'(expAddrQ.pop_front());
               void'(expDataQ.pop_front());
            end
         end
      end
   end

   function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
      return {opRtype, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Working set is $1..$7
   function automatic logic [4:0] randReg();
      return 5'($urandom_range(1, 7));
   endfunction

   function automatic logic [5:0] randFn();
      logic [5:0] fns [5];
      fns = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
      return fns[$urandom_range(0, 4)];
   endfunction

   // Mode 0 ALU, 1 dependent chain, 2 load/store, 3 branches, 4 mix
   task automatic buildProgram(input int mode, input int bodyLen);
      int         pc;
      int         kind;
      int         off;
      logic [4:0] d;
      logic [4:0] src;
      logic [4:0] rs;
      logic [4:0] prevD;
      logic [4:0] prevPrevD;
      pc = 0;
      prevD = 5'd1;
      prevPrevD = 5'd2;
      // Registers and low data words start known in every program
      for (int k = 1; k <= 7; k++) begin
         prog[pc] = encI(opAddi, 5'd0, 5'(k), 16'($urandom));
         pc++;
      end
      for (int k = 1; k <= 7; k++) begin
         prog[pc] = encI(opSw, 5'd0, 5'(k), 16'(k * 4));
         pc++;
      end
      haltIdx = pc + bodyLen;
      while (pc < haltIdx) begin
         kind = (mode == 4) ? $urandom_range(0, 3) : mode;
         if (mode == 3 && $urandom_range(0, 1) == 0) begin
            kind = 0;
         end
         d = randReg();
         case (kind)
            0: begin
               if ($urandom_range(0, 5) == 0) begin
                  prog[pc] = encI(opAddi, randReg(), d, 16'($urandom));
               end else begin
                  prog[pc] = encR(randReg(), randReg(), d, randFn());
               end
            end
            // Source from distance one or two
            1: begin
               src = $urandom_range(0, 1) ? prevD : prevPrevD;
               if ($urandom_range(0, 1) == 0) begin
                  prog[pc] = encR(src, randReg(), d, randFn());
               end else begin
                  prog[pc] = encR(randReg(), src, d, randFn());
               end
            end
            2: begin
               if (pc + 1 < haltIdx && $urandom_range(0, 1) == 0) begin
                  // Load then immediate use forces a stall
                  prog[pc] = encI(opLw, 5'd0, d, 16'($urandom_range(1, 7) * 4));
                  pc++;
                  prog[pc] = encR(d, randReg(), randReg(), randFn());
               end else begin
                  prog[pc] = encI(opSw, 5'd0, prevD, 16'($urandom_range(0, 63) * 4));
               end
            end
            default: begin
               off = $urandom_range(0, 3);
               if (off > haltIdx - pc - 1) begin
                  off = haltIdx - pc - 1;
               end
               rs = randReg();
               prog[pc] = encI(opBeq, rs, $urandom_range(0, 1) ? rs : randReg(), 16'(off));
            end
         endcase
         prevPrevD = prevD;
         prevD = d;
         pc++;
      end
      // Self loop halts fetch inside the program
      prog[pc] = encI(opBeq, 5'd0, 5'd0, 16'hffff);
      pc++;
      while (pc < imemDepth) begin
         prog[pc] = 32'h0;
         pc++;
      end
   endtask

   // In-order ISA execution up to the halt
   task automatic runModel();
      int          pc;
      int          steps;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] v;
      logic [31:0] addr;
      logic [4:0]  dest;
      logic        wr;
      pc = 0;
      steps = 0;
      while (pc != haltIdx && steps < 200) begin
         w = prog[pc];
         a = modelRegs[w[25:21]];
         b = modelRegs[w[20:16]];
         imm = {{16{w[15]}}, w[15:0]};
         dest = w[20:16];
         wr = 1'b0;
         v = '0;
         pc++;
         case (w[31:26])
            opRtype: begin
               dest = w[15:11];
               wr = 1'b1;
               case (w[5:0])
                  fnSub:   v = a - b;
                  fnAnd:   v = a & b;
                  fnOr:    v = a | b;
                  fnSlt:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: v = a + b;
               endcase
            end
            opAddi: begin
               v = a + imm;
               wr = 1'b1;
            end
            opLw: begin
               addr = a + imm;
               v = modelMem[addr[7:2]];
               wr = 1'b1;
            end
            opSw: begin
               addr = a + imm;
               modelMem[addr[7:2]] = b;
               expAddrQ.push_back(addr);
               expDataQ.push_back(b);
            end
            opBeq: begin
               if (a == b) begin
                  pc = pc + $signed(imm);
               end
            end
            default: begin
               wr = 1'b0;
            end
         endcase
         if (wr && dest != 5'd0) begin
            modelRegs[dest] = v;
            expRegQ.push_back(dest);
            expValQ.push_back(v);
         end
         steps++;
      end
   endtask

   task automatic runTest(input string name, input int mode, input int bodyLen);
      int waitCycles;
      testName = name;
      testErrors = 0;
      expRegQ.delete();
      expValQ.delete();
      expAddrQ.delete();
      expDataQ.delete();
      buildProgram(mode, bodyLen);
      runModel();
      // Core held in reset while the whole store is loaded
      @(negedge Clk);
      rstN = 1'b0;
      for (int k = 0; k < imemDepth; k++) begin
         imemWe = 1'b1;
         imemAddr = memIdxWidth'(k);
         imemData = prog[k];
         @(negedge Clk);
      end
      imemWe = 1'b0;
      rstN = 1'b1;
      waitCycles = 0;
      while ((expRegQ.size() > 0 || expAddrQ.size() > 0) && waitCycles < drainLimit) begin
         @(negedge Clk);
         waitCycles++;
      end
      if (expRegQ.size() > 0 || expAddrQ.size() > 0) begin
         reportFailure($sformatf("timed out with %0d writes and %0d stores still expected",
                                 expRegQ.size(), expAddrQ.size()));
      end
      // Window for stray events after the last expected one
      repeat (12) @(negedge Clk);
      testsRun++;
      totalErrors += testErrors;
      if (testErrors == 0) begin
         $display("PASS %s", name);
      end else begin
         testsFailed++;
         $display("FAIL %s with %0d errors", name, testErrors);
      end
   endtask

   initial begin
      void'($urandom(32'hf038));
      rstN = 1'b0;
      imemWe = 1'b0;
      imemAddr = '0;
      imemData = '0;
      testErrors = 0;
      totalErrors = 0;
      testsRun = 0;
      testsFailed = 0;
      for (int k = 0; k < 32; k++) begin
         modelRegs[k] = '0;
      end
      repeat (4) @(negedge Clk);
      runTest("resetFirstRetire", 0, 8);
      runTest("aluIndependent", 0, 30);
      runTest("forwarding", 1, 30);
      runTest("loadStore", 2, 30);
      runTest("branches", 3, 30);
      for (int k = 0; k < 3; k++) begin
         runTest($sformatf("randomMix%0d", k), 4, 40);
      end
      $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
      if (totalErrors == 0 && testsFailed == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Whole-run limit
   initial begin
      int cycles;
      cycles = 0;
      while (cycles < runLimit) begin
         @(posedge Clk);
         cycles++;
      end
      $display("Simulation exceeded %0d cycles without finishing", runLimit);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

bind mipsCore coreProperties props (
   .Clk      (Clk),
   .rstN     (rstN),
   .wbValid  (wbValid),
   .wbReg    (wbReg),
   .wbData   (wbData),
   .dmemWe   (dmemWe),
   .dmemData (dmemData)
);

`default_nettype wire

// ==== files.f ====
source/mipsPkg.sv
source/fetchUnit.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/mipsCore.sv
sim/core_properties.sv
sim/mipsTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mipsTb
FILELIST  := files.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
LOG       := sim.log

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
